// File: Makefile
VERILATOR ?= verilator
TOP       ?= lacore_tb
RTL_TOP   ?= lacore_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Done: errors found

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only +incdir+include source/*.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+include
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_control.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu_exec.sv
source/lacore_top.sv
verification/lacore_properties.sv
verification/lacore_tb.sv

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// word and register file geometry
`define CORE_XLEN 32
`define CORE_NREGS 32

// first fetch address out of reset
`define CORE_RESET_PC 32'h1c00_0000

`endif

// File: source/alu_exec.sv
module alu_exec (
    input  core_pkg::word_t   pc,
    input  isa_pkg::decoded_t dec,
    input  core_pkg::word_t   rdata1,
    input  core_pkg::word_t   rdata2,
    output core_pkg::word_t   result,
    output core_pkg::word_t   next_pc
);
    import core_pkg::*;
    import isa_pkg::*;

    localparam int SHAMT_W = $clog2($bits(word_t));

    word_t              src1;
    word_t              src2;
    word_t              seq_pc;
    word_t              target;
    logic [SHAMT_W-1:0] shamt;
    logic               taken;

    assign seq_pc = pc + word_t'(4);

    //////////////////////////////////////////////////////////////////////
    // operands and ALU
    //////////////////////////////////////////////////////////////////////
    assign src1 = dec.src1_is_pc ? pc : rdata1;
    // link instructions add 4 to pc since imm holds the branch offset
    assign src2 = !dec.src2_is_imm         ? rdata2  :
                  (dec.br_kind == BR_NONE) ? dec.imm :
                  word_t'(4);
    assign shamt = src2[SHAMT_W-1:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: result = word_t'(src1 < src2);
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = word_t'($signed(src1) >>> shamt);
            ALU_LUI:  result = src2;
            default:  result = src1 + src2;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch decision and next pc
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (dec.br_kind)
            BR_BEQ:                taken = (rdata1 == rdata2);
            BR_BNE:                taken = (rdata1 != rdata2);
            BR_B, BR_BL, BR_JIRL:  taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target  = (dec.br_kind == BR_JIRL) ? rdata1 + dec.imm : pc + dec.imm;
    assign next_pc = taken ? target : seq_pc;

endmodule

// File: source/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

    // fetch sequencer
    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_REL,
        EXECUTE
    } seq_state_t;

endpackage

// File: source/fetch_control.sv
`include "core_settings.svh"

module fetch_control (
    input  logic            clk,
    input  logic            resetn,
    input  logic            inst_ack,
    input  core_pkg::word_t inst_rdata,
    input  core_pkg::word_t next_pc,
    input  logic            gr_we,
    output logic            inst_req,
    output core_pkg::word_t inst_addr,
    output core_pkg::word_t pc,
    output core_pkg::word_t inst_word,
    output logic            rf_we
);
    import core_pkg::*;

    seq_state_t state;
    logic       fetch_done;

    // ack seen while our request is up
    assign fetch_done = (state == FETCH_REQ) && inst_req && inst_ack;

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= FETCH_REQ;
            inst_req <= 1'b0;
            pc       <= `CORE_RESET_PC;
        end else begin
            case (state)
                FETCH_REQ: begin
                    if (fetch_done) begin
                        // drop request once the word is captured
                        inst_req <= 1'b0;
                        state    <= FETCH_REL;
                    end else begin
                        inst_req <= 1'b1;
                    end
                end
                FETCH_REL: begin
                    // wait for memory to release ack
                    if (!inst_ack) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    pc       <= next_pc;
                    inst_req <= 1'b1;
                    state    <= FETCH_REQ;
                end
                default: begin
                    inst_req <= 1'b0;
                    state    <= FETCH_REQ;
                end
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst_word <= inst_rdata;
        end
    end

    assign inst_addr = pc;

    // register write only in the single execute cycle
    assign rf_we = (state == EXECUTE) && gr_we;

endmodule

// File: source/inst_decoder.sv
module inst_decoder (
    input  core_pkg::word_t   inst_word,
    output isa_pkg::decoded_t dec
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [5:0]  op_a;
    logic [3:0]  op_b;
    logic [1:0]  op_c;
    logic [4:0]  op_d;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        grp_3r;
    logic        grp_sft;

    assign op_a = inst_word[OPC_A_MSB:OPC_A_LSB];
    assign op_b = inst_word[OPC_B_MSB:OPC_B_LSB];
    assign op_c = inst_word[OPC_C_MSB:OPC_C_LSB];
    assign op_d = inst_word[OPC_D_MSB:OPC_D_LSB];

    assign rd  = inst_word[4:0];
    assign rj  = inst_word[9:5];
    assign rk  = inst_word[14:10];
    assign i12 = inst_word[21:10];
    assign i20 = inst_word[24:5];
    assign i16 = inst_word[25:10];
    assign i26 = {inst_word[9:0], inst_word[25:10]};

    // register-register and shift-immediate groups
    assign grp_3r  = (op_a == 6'h00) && (op_b == 4'h0) && (op_c == 2'h1);
    assign grp_sft = (op_a == 6'h00) && (op_b == 4'h1) && (op_c == 2'h0);

    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.br_kind  = BR_NONE;
        dec.rj       = rj;
        dec.rk_or_rd = rk;
        dec.dest     = rd;
        if (grp_3r) begin
            dec.gr_we = 1'b1;
            case (op_d)
                5'h00: dec.alu_op = ALU_ADD;
                5'h02: dec.alu_op = ALU_SUB;
                5'h04: dec.alu_op = ALU_SLT;
                5'h05: dec.alu_op = ALU_SLTU;
                5'h08: dec.alu_op = ALU_NOR;
                5'h09: dec.alu_op = ALU_AND;
                5'h0a: dec.alu_op = ALU_OR;
                5'h0b: dec.alu_op = ALU_XOR;
                default: dec.gr_we = 1'b0;
            endcase
        end else if (grp_sft) begin
            // shift amount sits in the rk field
            dec.gr_we       = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = word_t'(rk);
            case (op_d)
                5'h01: dec.alu_op = ALU_SLL;
                5'h09: dec.alu_op = ALU_SRL;
                5'h11: dec.alu_op = ALU_SRA;
                default: dec.gr_we = 1'b0;
            endcase
        end else if (op_a == 6'h00) begin
            dec.gr_we       = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = word_t'(i12);
            case (op_b)
                4'ha: begin
                    dec.alu_op = ALU_ADD;
                    dec.imm    = word_t'($signed(i12));
                end
                4'hd: dec.alu_op = ALU_AND;
                4'he: dec.alu_op = ALU_OR;
                4'hf: dec.alu_op = ALU_XOR;
                default: dec.gr_we = 1'b0;
            endcase
        end else if ((op_a == 6'h05) && !inst_word[25]) begin
            dec.alu_op      = ALU_LUI;
            dec.gr_we       = 1'b1;
            dec.src2_is_imm = 1'b1;
            dec.imm         = word_t'({i20, 12'h000});
        end else begin
            // branches keep their word offset in imm
            case (op_a)
                6'h13: begin
                    dec.br_kind     = BR_JIRL;
                    dec.imm         = word_t'($signed({i16, 2'b00}));
                    dec.src1_is_pc  = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.gr_we       = 1'b1;
                end
                6'h14: begin
                    dec.br_kind = BR_B;
                    dec.imm     = word_t'($signed({i26, 2'b00}));
                end
                6'h15: begin
                    dec.br_kind     = BR_BL;
                    dec.imm         = word_t'($signed({i26, 2'b00}));
                    dec.src1_is_pc  = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.gr_we       = 1'b1;
                    dec.dest        = reg_idx_t'(1);
                end
                6'h16, 6'h17: begin
                    dec.br_kind  = (op_a == 6'h16) ? BR_BEQ : BR_BNE;
                    dec.imm      = word_t'($signed({i16, 2'b00}));
                    dec.rk_or_rd = rd;
                end
                default: dec.br_kind = BR_NONE;
            endcase
        end
    end

endmodule

// File: source/isa_pkg.sv
`include "core_settings.svh"

package isa_pkg;

    // opcode field positions in the instruction word
    localparam int OPC_A_MSB = 31;
    localparam int OPC_A_LSB = 26;
    localparam int OPC_B_MSB = 25;
    localparam int OPC_B_LSB = 22;
    localparam int OPC_C_MSB = 21;
    localparam int OPC_C_LSB = 20;
    localparam int OPC_D_MSB = 19;
    localparam int OPC_D_LSB = 15;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR,  ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_JIRL
    } br_kind_t;

    // everything execute needs from one instruction
    typedef struct packed {
        alu_op_t                        alu_op;
        br_kind_t                       br_kind;
        logic [$clog2(`CORE_NREGS)-1:0] rj;
        logic [$clog2(`CORE_NREGS)-1:0] rk_or_rd;
        logic [$clog2(`CORE_NREGS)-1:0] dest;
        logic [`CORE_XLEN-1:0]          imm;
        logic                           src1_is_pc;
        logic                           src2_is_imm;
        logic                           gr_we;
    } decoded_t;

endpackage

// File: source/lacore_top.sv
module lacore_top (
    input  logic               clk,
    input  logic               resetn,
    output logic               inst_req,
    output core_pkg::word_t    inst_addr,
    input  logic               inst_ack,
    input  core_pkg::word_t    inst_rdata,
    output core_pkg::word_t    debug_wb_pc,
    output logic               debug_wb_rf_we,
    output core_pkg::reg_idx_t debug_wb_rf_wnum,
    output core_pkg::word_t    debug_wb_rf_wdata
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t    pc;
    word_t    inst_word;
    word_t    next_pc;
    word_t    result;
    word_t    rdata1;
    word_t    rdata2;
    decoded_t dec;
    logic     rf_we;

    fetch_control u_fetch (
        .clk        (clk),
        .resetn     (resetn),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .next_pc    (next_pc),
        .gr_we      (dec.gr_we),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .pc         (pc),
        .inst_word  (inst_word),
        .rf_we      (rf_we)
    );

    inst_decoder u_decode (
        .inst_word (inst_word),
        .dec       (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.rk_or_rd),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (dec.dest),
        .wdata  (result)
    );

    alu_exec u_exec (
        .pc      (pc),
        .dec     (dec),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .result  (result),
        .next_pc (next_pc)
    );

    // retirement trace taken during execute
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dec.dest;
    assign debug_wb_rf_wdata = result;

endmodule

// File: source/reg_file.sv
`include "core_settings.svh"

module reg_file (
    input  logic               clk,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2,
    input  logic               we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata
);
    import core_pkg::*;

    word_t regs [`CORE_NREGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verification/lacore_properties.sv
module lacore_properties (
    input logic            clk,
    input logic            resetn,
    input logic            inst_req,
    input core_pkg::word_t inst_addr,
    input logic            inst_ack,
    input logic            debug_wb_rf_we
);
    int fail_count;

    // request held until memory answers
    req_held: assert property (@(posedge clk) disable iff (!resetn)
        inst_req && !inst_ack |=> inst_req)
    else begin
        fail_count++;
        $error("inst_req dropped before inst_ack rose");
    end

    addr_stable: assert property (@(posedge clk) disable iff (!resetn)
        inst_req |=> !inst_req || $stable(inst_addr))
    else begin
        fail_count++;
        $error("inst_addr changed while inst_req was high");
    end

    // new request only after ack is released
    req_after_release: assert property (@(posedge clk) disable iff (!resetn)
        $rose(inst_req) |-> !inst_ack)
    else begin
        fail_count++;
        $error("inst_req rose while inst_ack was still high");
    end

    single_retire: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_we |=> !debug_wb_rf_we)
    else begin
        fail_count++;
        $error("debug_wb_rf_we high for two cycles in a row");
    end

endmodule

// File: verification/lacore_tb.sv
`include "core_settings.svh"

module lacore_tb;
    import core_pkg::*;

    localparam int   CLK_PERIOD = 40;
    localparam int   PROG_WORDS = 256;
    localparam int   ROUNDS     = 6;
    localparam int   MAX_DELAY  = 3;
    // every program word at the slowest handshake, plus reset
    localparam int   WATCHDOG_CYCLES = PROG_WORDS * (2 * MAX_DELAY + 6) + 16;
    localparam word_t RESET_PC  = `CORE_RESET_PC;
    localparam word_t LFSR_TAPS = 32'h8020_0003;
    localparam word_t UNDEF     = 32'hffff_ffff;
    localparam logic [4:0] OPD_3R [8] = '{5'h00, 5'h02, 5'h04, 5'h05,
                                          5'h08, 5'h09, 5'h0a, 5'h0b};

    logic     clk;
    logic     resetn;
    logic     inst_req;
    word_t    inst_addr;
    logic     inst_ack = 1'b0;
    word_t    inst_rdata = '0;
    word_t    debug_wb_pc;
    logic     debug_wb_rf_we;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t lfsr = 32'd75990;
    word_t prog [PROG_WORDS];
    int    plen;
    word_t end_pc;
    word_t mregs [`CORE_NREGS];
    word_t model_pc;
    int    checks;
    int    errors;
    int    ack_wait;
    int    rel_wait;

    lacore_top DUT (.*);

    bind lacore_top lacore_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    // galois shift, one step per bit taken
    function automatic word_t lfsr_bits(input int n);
        word_t bits;
        int    i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : '0);
        end
        return bits;
    endfunction

    function automatic word_t random_alu();
        logic [3:0]  kind;
        logic [14:0] fld;
        logic [11:0] imm;
        kind = 4'(lfsr_bits(4));
        fld  = 15'(lfsr_bits(15));
        imm  = 12'(lfsr_bits(12));
        case (kind)
            4'd8:    return {10'h00a, imm, fld[9:0]};
            4'd9:    return {10'h00d, imm, fld[9:0]};
            4'd10:   return {10'h00e, imm, fld[9:0]};
            4'd11:   return {10'h00f, imm, fld[9:0]};
            4'd12:   return {17'h00081, fld};
            4'd13:   return {17'h00089, fld};
            4'd14:   return {17'h00091, fld};
            4'd15:   return {7'h0a, imm, fld[14:7], fld[4:0]};
            default: return {12'h001, OPD_3R[kind[2:0]], fld};
        endcase
    endfunction

    task automatic put(input word_t w);
        prog[plen] = w;
        plen++;
    endtask

    // forward-only branches, every path rejoins at the block end
    task automatic put_branch_block();
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    t;
        ra = reg_idx_t'(lfsr_bits(5));
        rb = reg_idx_t'(lfsr_bits(5));
        put({6'h16, 16'd2, ra, rb});
        put(random_alu());
        put({6'h17, 16'd2, ra, rb});
        put(random_alu());
        // bne on equal operands always falls through
        put({6'h17, 16'd2, ra, ra});
        put(random_alu());
        put({6'h16, 16'd2, ra, ra});
        put(UNDEF);
        put({6'h15, 16'd3, 10'd0});
        put(UNDEF);
        put(UNDEF);
        put({6'h14, 16'd2, 10'd0});
        put(UNDEF);
        // jirl target lands one word past r12
        t = RESET_PC + word_t'(4 * (plen + 3));
        put({7'h0a, t[31:12], 5'd12});
        put({10'h00e, t[11:0], 5'd12, 5'd12});
        put({6'h13, 16'd1, 5'd12, 5'd13});
        put(UNDEF);
    endtask

    task automatic build_program();
        int r;
        int i;
        plen = 0;
        for (r = 1; r < `CORE_NREGS; r++) begin
            put({10'h00a, 12'(lfsr_bits(12)), 5'd0, 5'(r)});
        end
        // write r0, then read it back twice
        put({10'h00a, 12'h7ff, 5'd5, 5'd0});
        put({12'h001, 5'h0a, 5'd0, 5'd0, 5'd6});
        put({12'h001, 5'h00, 5'd0, 5'd3, 5'd7});
        for (r = 0; r < ROUNDS; r++) begin
            for (i = 0; i < 16; i++) begin
                put(random_alu());
            end
            put_branch_block();
        end
        put(UNDEF);
        put(32'h0000_0000);
        put(32'h0011_8000);
        end_pc = RESET_PC + word_t'(4 * plen);
    endtask

    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr[1:0] == 2'b00 && idx < word_t'(plen)) begin
            return prog[idx[7:0]];
        end
        return {6'h3f, addr[25:0] ^ {20'h0, addr[31:26]}};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic void ref_exec(input word_t inst, input word_t pc, output logic we,
                                     output reg_idx_t wnum, output word_t wdata,
                                     output word_t npc);
        word_t vj;
        word_t vk;
        word_t vd;
        word_t si12;
        word_t ui12;
        word_t off16;
        word_t off26;
        vj    = mregs[inst[9:5]];
        vk    = mregs[inst[14:10]];
        vd    = mregs[inst[4:0]];
        si12  = {{20{inst[21]}}, inst[21:10]};
        ui12  = {20'h0, inst[21:10]};
        off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        we    = 1'b1;
        wnum  = inst[4:0];
        wdata = '0;
        npc   = pc + 32'd4;
        if (inst[31:22] == 10'h000 || inst[31:22] == 10'h001) begin
            case (inst[31:15])
                17'h00020: wdata = vj + vk;
                17'h00022: wdata = vj - vk;
                17'h00024: wdata = {31'd0, $signed(vj) < $signed(vk)};
                17'h00025: wdata = {31'd0, vj < vk};
                17'h00028: wdata = ~(vj | vk);
                17'h00029: wdata = vj & vk;
                17'h0002a: wdata = vj | vk;
                17'h0002b: wdata = vj ^ vk;
                17'h00081: wdata = vj << inst[14:10];
                17'h00089: wdata = vj >> inst[14:10];
                17'h00091: wdata = word_t'($signed(vj) >>> inst[14:10]);
                default:   we = 1'b0;
            endcase
        end else if (inst[31:25] == 7'h0a) begin
            wdata = {inst[24:5], 12'h000};
        end else begin
            case (inst[31:22])
                10'h00a: wdata = vj + si12;
                10'h00d: wdata = vj & ui12;
                10'h00e: wdata = vj | ui12;
                10'h00f: wdata = vj ^ ui12;
                default: begin
                    we = 1'b0;
                    case (inst[31:26])
                        6'h13: begin
                            we    = 1'b1;
                            wdata = pc + 32'd4;
                            npc   = vj + off16;
                        end
                        6'h14: npc = pc + off26;
                        6'h15: begin
                            we    = 1'b1;
                            wnum  = 5'd1;
                            wdata = pc + 32'd4;
                            npc   = pc + off26;
                        end
                        6'h16: npc = (vj == vd) ? pc + off16 : npc;
                        6'h17: npc = (vj != vd) ? pc + off16 : npc;
                        default: ;
                    endcase
                end
            endcase
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // instruction memory with random ack and release delays
    always @(posedge clk) begin
        if (!resetn) begin
            inst_ack <= 1'b0;
            ack_wait <= 0;
            rel_wait <= 0;
        end else if (!inst_ack) begin
            if (inst_req && ack_wait == 0) begin
                inst_ack   <= 1'b1;
                inst_rdata <= fetch_word(inst_addr);
                rel_wait   <= int'(lfsr_bits(2));
            end else if (inst_req) begin
                ack_wait <= ack_wait - 1;
            end
        end else if (!inst_req) begin
            if (rel_wait == 0) begin
                inst_ack <= 1'b0;
                ack_wait <= int'(lfsr_bits(2));
            end else begin
                rel_wait <= rel_wait - 1;
            end
        end
    end

    initial begin : main
        word_t    inst;
        word_t    exp_wdata;
        word_t    npc;
        logic     exp_we;
        logic     saw_we;
        reg_idx_t exp_wnum;
        resetn <= 1'b0;
        build_program();
        foreach (mregs[k]) mregs[k] = '0;
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("inst_req", inst_req, 1'b0);
            check_flag("debug_wb_rf_we", debug_wb_rf_we, 1'b0);
        end
        @(posedge clk);
        resetn <= 1'b1;
        model_pc = RESET_PC;
        @(negedge clk);
        forever begin
            while (!inst_req) @(negedge clk);
            check_word("inst_addr", inst_addr, model_pc);
            if (model_pc == end_pc) break;
            inst = fetch_word(model_pc);
            ref_exec(inst, model_pc, exp_we, exp_wnum, exp_wdata, npc);
            saw_we = 1'b0;
            do @(negedge clk); while (inst_req);
            // the execute cycle falls between the two requests
            while (!inst_req) begin
                if (debug_wb_rf_we) begin
                    saw_we = 1'b1;
                    check_word("debug_wb_pc", debug_wb_pc, model_pc);
                    check_reg_idx("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wnum);
                    check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata);
                end
                @(negedge clk);
            end
            check_flag("debug_wb_rf_we", saw_we, exp_we);
            if (exp_we && exp_wnum != '0) mregs[exp_wnum] = exp_wdata;
            model_pc = npc;
        end
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the core did not reach the end of the program in time");
        $display("Done: errors found");
        $finish;
    end

endmodule
